/* src.f */
hdl/bmm_pkg.sv
hdl/dot_core.sv
hdl/requant_stage.sv
hdl/b2r_converter.sv
hdl/block_matmul_top.sv
verif/result_checker.sv
verif/tb_block_matmul.sv

/* verif/tb_block_matmul.sv */
// ####################
// Block matmul testbench
// ####################

`timescale 1ns/10ps

module tb_block_matmul;

    localparam int WIDTH        = 16;
    localparam int FRAC_WIDTH   = 8;
    localparam int ROW          = 4;
    localparam int COL          = 8;
    localparam int BLOCK_SIZE   = 2;
    localparam int NUM_CORES    = 2;
    localparam int DEPTH        = 4;
    localparam int LANES        = BLOCK_SIZE * NUM_CORES;
    localparam int DOTS         = ROW * COL / LANES;
    localparam int BEATS        = DOTS * DEPTH;
    localparam int NUM_RUNS     = 5;
    localparam int MAX_GAP      = 5;
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG_CYCLES =
        NUM_RUNS * (BEATS + ROW * MAX_GAP + 20) + RESET_CYCLES + 20;

    localparam logic [1:0] KIND_RAND  = 2'd0;
    localparam logic [1:0] KIND_HALF  = 2'd1;
    localparam logic [1:0] KIND_LARGE = 2'd2;

    typedef struct packed {
        bmm_pkg::round_mode_t mode;
        logic [1:0]           kind;
        logic [15:0]          span;
        logic [3:0]           gap;
        logic                 extra;
    } run_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         start;
    bmm_pkg::round_mode_t         mode;
    logic                         in_valid;
    logic                         in_last;
    logic [WIDTH*LANES-1:0]       in_a;
    logic [WIDTH*LANES-1:0]       in_b;
    logic                         row_ready;
    logic                         row_valid;
    logic [WIDTH*COL-1:0]         row_data;
    logic                         done;

    run_t                 run_table [NUM_RUNS];
    int                   op_a [BEATS*LANES];
    int                   op_b [BEATS*LANES];
    logic [WIDTH*COL-1:0] exp_rows [ROW];
    logic [31:0]          lcg_state  = 32'h3f53_0c51;
    int                   done_count = 0;
    int                   total_errors;

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && done) begin
            done_count++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_range(input int span);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:8] % (2 * span + 1)) - span;
    endfunction

    // Round, shift out the fraction, clamp to the signed output range
    function automatic int requant_ref(input longint sum, input logic nearest);
        longint v;
        longint q_max;
        longint q_min;
        q_max = (longint'(1) << (WIDTH - 1)) - 1;
        q_min = -(longint'(1) << (WIDTH - 1));
        v = nearest ? sum + (longint'(1) << (FRAC_WIDTH - 1)) : sum;
        v = v >>> FRAC_WIDTH;
        if (v > q_max) begin
            v = q_max;
        end else if (v < q_min) begin
            v = q_min;
        end
        return int'(v);
    endfunction

    task automatic set_run(input int idx, input bmm_pkg::round_mode_t m, input logic [1:0] kind,
                           input int span, input int gap, input logic extra);
        run_table[idx].mode  = m;
        run_table[idx].kind  = kind;
        run_table[idx].span  = 16'(span);
        run_table[idx].gap   = 4'(gap);
        run_table[idx].extra = extra;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic build_run(input int r);
        int     span;
        int     idx;
        int     e;
        int     sa;
        int     q;
        longint sum;
        span = int'(run_table[r].span);
        for (int d = 0; d < DOTS; d++) begin
            for (int l = 0; l < LANES; l++) begin
                e   = d * LANES + l;
                sum = 0;
                for (int j = 0; j < DEPTH; j++) begin
                    idx = (d * DEPTH + j) * LANES + l;
                    case (run_table[r].kind)
                        KIND_HALF: begin
                            // Beat 0 sits on or next to half an LSB, the rest are whole LSBs
                            op_a[idx] = (j == 0) ?
                                ((e % 2) ? -1 : 1) * ((1 << (FRAC_WIDTH - 1)) + (e / 2) % 3 - 1) :
                                rand_range(span) * (1 << FRAC_WIDTH);
                            op_b[idx] = 1;
                        end
                        KIND_LARGE: begin
                            sa = (rand_range(1) >= 0) ? 1 : -1;
                            op_a[idx] = sa * (32000 + rand_range(span));
                            op_b[idx] = ((e % 2) ? -sa : sa) * (32000 + rand_range(span));
                        end
                        default: begin
                            op_a[idx] = rand_range(span);
                            op_b[idx] = rand_range(span);
                        end
                    endcase
                    sum += longint'(op_a[idx]) * longint'(op_b[idx]);
                end
                q = requant_ref(sum, run_table[r].mode == bmm_pkg::RND_NEAREST);
                exp_rows[e / COL][(e % COL) * WIDTH +: WIDTH] = q[WIDTH-1:0];
            end
        end
    endtask

    task automatic send_dots();
        int idx;
        for (int d = 0; d < DOTS; d++) begin
            for (int j = 0; j < DEPTH; j++) begin
                in_valid = 1'b1;
                in_last  = (j == DEPTH - 1);
                for (int l = 0; l < LANES; l++) begin
                    idx = (d * DEPTH + j) * LANES + l;
                    in_a[l*WIDTH +: WIDTH] = WIDTH'(op_a[idx]);
                    in_b[l*WIDTH +: WIDTH] = WIDTH'(op_b[idx]);
                end
                next_cycle();
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic request_rows(input int r);
        for (int k = 0; k < ROW + run_table[r].extra; k++) begin
            row_ready = 1'b1;
            next_cycle();
            row_ready = 1'b0;
            repeat (run_table[r].gap) next_cycle();
        end
    endtask

    block_matmul_top #(
        .WIDTH      (WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH),
        .ROW        (ROW),
        .COL        (COL),
        .BLOCK_SIZE (BLOCK_SIZE),
        .NUM_CORES  (NUM_CORES),
        .DEPTH      (DEPTH)
    ) i_block_matmul_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_a      (in_a),
        .in_b      (in_b),
        .row_ready (row_ready),
        .row_valid (row_valid),
        .row_data  (row_data),
        .done      (done)
    );

    result_checker #(
        .WIDTH    (WIDTH),
        .ROW      (ROW),
        .COL      (COL),
        .NUM_RUNS (NUM_RUNS)
    ) i_result_checker (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .row_ready (row_ready),
        .row_valid (row_valid),
        .row_data  (row_data),
        .done      (done)
    );

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        mode      = bmm_pkg::RND_TRUNC;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_a      = '0;
        in_b      = '0;
        row_ready = 1'b0;
        // mode, operand kind, range, request gap, extra request
        set_run(0, bmm_pkg::RND_TRUNC,   KIND_RAND,  127,  0, 1'b1);
        set_run(1, bmm_pkg::RND_NEAREST, KIND_HALF,  60,   1, 1'b0);
        set_run(2, bmm_pkg::RND_TRUNC,   KIND_LARGE, 700,  5, 1'b1);
        set_run(3, bmm_pkg::RND_NEAREST, KIND_RAND,  2000, 1, 1'b0);
        set_run(4, bmm_pkg::RND_NEAREST, KIND_LARGE, 700,  0, 1'b0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet period, no row may show up here
        repeat (5) next_cycle();
        for (int r = 0; r < NUM_RUNS; r++) begin
            mode = run_table[r].mode;
            build_run(r);
            start = 1'b1;
            next_cycle();
            start = 1'b0;
            send_dots();
            // Last beat lands in the store two cycles later
            repeat (3) next_cycle();
            request_rows(r);
            while (done_count <= r) next_cycle();
        end
        repeat (4) next_cycle();
        i_result_checker.report_totals(total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run stalled", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* verif/result_checker.sv */
// ####################
// Row result checker
// ####################

`timescale 1ns/10ps

module result_checker #(
    parameter int WIDTH    = 16,
    parameter int ROW      = 4,
    parameter int COL      = 8,
    parameter int NUM_RUNS = 1
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 row_ready,
    input logic                 row_valid,
    input logic [WIDTH*COL-1:0] row_data,
    input logic                 done
);

    int   error_count    = 0;
    int   run_errors     = 0;
    int   run_count      = 0;
    int   row_count      = 0;
    int   row_idx        = 0;
    int   req_count      = 0;
    int   cycle          = 0;
    int   last_row_cycle = 0;
    logic prev_ready     = 1'b0;
    logic prev_done      = 1'b0;

    task automatic check_row();
        logic [WIDTH-1:0] got;
        logic [WIDTH-1:0] exp;
        for (int c = 0; c < COL; c++) begin
            got = row_data[c*WIDTH +: WIDTH];
            exp = tb_block_matmul.exp_rows[row_idx][c*WIDTH +: WIDTH];
            if (got !== exp) begin
                $display("** Error at %0t ns: row_data row %0d col %0d = %0d, expected %0d",
                         $time, row_idx, c, $signed(got), $signed(exp));
                run_errors++;
            end
        end
    endtask

    task automatic finish_run();
        bmm_pkg::conv_state_t st;
        st = tb_block_matmul.i_block_matmul_top.i_b2r_converter.state;
        if (row_idx != ROW) begin
            $display("done came after %0d rows instead of %0d, converter in %s",
                     row_idx, ROW, st.name());
            run_errors++;
        end else if (cycle - last_row_cycle != 2) begin
            $display("done came %0d cycles after the last row instead of 2",
                     cycle - last_row_cycle);
            run_errors++;
        end
        $display("Run %0d finished at %0t ns: %0d rows, %0d errors",
                 run_count, $time, row_idx, run_errors);
        error_count += run_errors;
        row_count   += row_idx;
        run_count++;
        run_errors = 0;
        row_idx    = 0;
    endtask

    task automatic report_totals(output int total_errors);
        error_count += run_errors;
        if (run_count != NUM_RUNS) begin
            $display("%0d runs signalled done, expected %0d", run_count, NUM_RUNS);
            error_count++;
        end
        $display("Totals: %0d runs, %0d rows, %0d errors", run_count, row_count, error_count);
        total_errors = error_count;
    endtask

    // Mid-cycle sampling, all outputs settled
    always @(negedge clk) begin
        cycle++;
        if (rst) begin
            if (row_valid !== 1'b0 || done !== 1'b0) begin
                $display("row_valid or done not low during reset at %0t ns", $time);
                run_errors++;
            end
        end else begin
            if (start) begin
                req_count = 0;
            end
            // The first ROW requests of a run each owe a row one cycle later
            if (prev_ready) begin
                if (req_count < ROW && row_valid !== 1'b1) begin
                    $display("No row at %0t ns for request %0d of the run",
                             $time, req_count);
                    run_errors++;
                end
                req_count++;
            end
            if (row_valid) begin
                if (!prev_ready) begin
                    $display("row_valid at %0t ns came without a request", $time);
                    run_errors++;
                end
                if (row_idx < ROW) begin
                    check_row();
                end else begin
                    $display("More than %0d rows in one run at %0t ns", ROW, $time);
                    run_errors++;
                end
                row_idx++;
                last_row_cycle = cycle;
            end
            if (done && prev_done) begin
                $display("done high for more than one cycle at %0t ns", $time);
                run_errors++;
            end else if (done) begin
                finish_run();
            end
        end
        prev_ready = row_ready;
        prev_done  = done;
    end

endmodule

/* hdl/block_matmul_top.sv */
// ####################
// Block matmul engine
// ####################

`timescale 1ns/10ps

module block_matmul_top #(
    parameter int WIDTH      = 16,
    parameter int FRAC_WIDTH = 8,
    parameter int ROW        = 4,
    parameter int COL        = 8,
    parameter int BLOCK_SIZE = 2,
    parameter int NUM_CORES  = 2,
    parameter int DEPTH      = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  bmm_pkg::round_mode_t                 mode,
    input  logic                                 in_valid,
    input  logic                                 in_last,
    input  logic [WIDTH*BLOCK_SIZE*NUM_CORES-1:0] in_a,
    input  logic [WIDTH*BLOCK_SIZE*NUM_CORES-1:0] in_b,
    input  logic                                 row_ready,
    output logic                                 row_valid,
    output logic [WIDTH*COL-1:0]                 row_data,
    output logic                                 done
);

    localparam int LANES    = BLOCK_SIZE * NUM_CORES;
    localparam int ACC_W    = 2 * WIDTH + bmm_pkg::ACC_GUARD;
    localparam int CORE_W   = WIDTH * BLOCK_SIZE;
    localparam int CORE_ACC = ACC_W * BLOCK_SIZE;

    logic [NUM_CORES-1:0]   core_valid;
    logic [ACC_W*LANES-1:0] acc_data;
    logic                   acc_valid;
    logic                   q_valid;
    logic [WIDTH*LANES-1:0] q_data;

    // Guard bits must cover the longest dot product
    if (DEPTH > (1 << bmm_pkg::ACC_GUARD)) begin : g_depth_check
        $error("DEPTH %0d exceeds the accumulator guard range", DEPTH);
    end

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        dot_core #(
            .WIDTH      (WIDTH),
            .BLOCK_SIZE (BLOCK_SIZE)
        ) i_dot_core (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (in_valid),
            .in_last   (in_last),
            .in_a      (in_a[c*CORE_W +: CORE_W]),
            .in_b      (in_b[c*CORE_W +: CORE_W]),
            .acc_valid (core_valid[c]),
            .acc_data  (acc_data[c*CORE_ACC +: CORE_ACC])
        );
    end

    // Cores run in lockstep
    assign acc_valid = &core_valid;

    requant_stage #(
        .WIDTH      (WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH),
        .LANES      (LANES)
    ) i_requant_stage (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .acc_valid (acc_valid),
        .acc_data  (acc_data),
        .q_valid   (q_valid),
        .q_data    (q_data)
    );

    b2r_converter #(
        .WIDTH      (WIDTH),
        .ROW        (ROW),
        .COL        (COL),
        .BLOCK_SIZE (BLOCK_SIZE),
        .NUM_CORES  (NUM_CORES)
    ) i_b2r_converter (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .top_valid (q_valid),
        .top_data  (q_data),
        .row_ready (row_ready),
        .row_valid (row_valid),
        .row_data  (row_data),
        .done      (done)
    );

endmodule

/* hdl/b2r_converter.sv */
// ####################
// Block to row converter
// ####################

`timescale 1ns/10ps

module b2r_converter #(
    parameter int WIDTH      = 16,
    parameter int ROW        = 4,
    parameter int COL        = 8,
    parameter int BLOCK_SIZE = 2,
    parameter int NUM_CORES  = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic                                 top_valid,
    input  logic [WIDTH*BLOCK_SIZE*NUM_CORES-1:0] top_data,
    input  logic                                 row_ready,
    output logic                                 row_valid,
    output logic [WIDTH*COL-1:0]                 row_data,
    output logic                                 done
);

    localparam int TOTAL_ELEM = ROW * COL;
    localparam int BEAT_ELEM  = BLOCK_SIZE * NUM_CORES;
    localparam int PTR_W      = $clog2(TOTAL_ELEM + 1);
    localparam int ROW_W      = $clog2(ROW + 1);

    bmm_pkg::conv_state_t state;
    bmm_pkg::conv_state_t next_state;

    logic [PTR_W-1:0] write_ptr;
    logic [ROW_W-1:0] read_row;
    logic             store;
    logic             serve;
    logic             last_beat;

    logic [WIDTH-1:0] elem_mem [TOTAL_ELEM];

    assign store     = top_valid && (state == bmm_pkg::CONV_WRITE);
    assign last_beat = store && (write_ptr == PTR_W'(TOTAL_ELEM - BEAT_ELEM));
    assign serve     = row_ready && (state == bmm_pkg::CONV_READ) && (read_row < ROW);

    always_comb begin
        next_state = state;
        case (state)
            bmm_pkg::CONV_IDLE: begin
                if (start) begin
                    next_state = bmm_pkg::CONV_WRITE;
                end
            end
            bmm_pkg::CONV_WRITE: begin
                if (last_beat) begin
                    next_state = bmm_pkg::CONV_READ;
                end
            end
            bmm_pkg::CONV_READ: begin
                // Leave only after the last row has gone out
                if (read_row == ROW_W'(ROW)) begin
                    next_state = bmm_pkg::CONV_DONE;
                end
            end
            default: begin
                next_state = bmm_pkg::CONV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= bmm_pkg::CONV_IDLE;
            write_ptr <= '0;
            read_row  <= '0;
            row_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= next_state;
            row_valid <= serve;
            done      <= (state == bmm_pkg::CONV_DONE);
            if (state == bmm_pkg::CONV_IDLE) begin
                write_ptr <= '0;
                read_row  <= '0;
            end else begin
                if (store) begin
                    write_ptr <= write_ptr + PTR_W'(BEAT_ELEM);
                end
                if (serve) begin
                    read_row <= read_row + 1'b1;
                end
            end
        end
    end

    // Element store, block order at increasing addresses
    always_ff @(posedge clk) begin
        if (store) begin
            for (int i = 0; i < BEAT_ELEM; i++) begin
                elem_mem[write_ptr + i] <= top_data[i*WIDTH +: WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            for (int c = 0; c < COL; c++) begin
                row_data[c*WIDTH +: WIDTH] <= elem_mem[read_row * COL + c];
            end
        end
    end

    a_beat_in_write: assert property (
        @(posedge clk) disable iff (rst) top_valid |-> state == bmm_pkg::CONV_WRITE
    ) else $error("Input beat outside collection, state %s", state.name());

    a_row_on_request: assert property (
        @(posedge clk) disable iff (rst) row_valid |-> $past(row_ready)
    ) else $error("row_valid without a request");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else $error("done high for two cycles");

endmodule

/* hdl/requant_stage.sv */
// ####################
// Requantization stage
// ####################

`timescale 1ns/10ps

module requant_stage #(
    parameter int WIDTH      = 16,
    parameter int FRAC_WIDTH = 8,
    parameter int LANES      = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  bmm_pkg::round_mode_t                            mode,
    input  logic                                            acc_valid,
    input  logic [(2*WIDTH+bmm_pkg::ACC_GUARD)*LANES-1:0]   acc_data,
    output logic                                            q_valid,
    output logic [WIDTH*LANES-1:0]                          q_data
);

    localparam int ACC_W = 2 * WIDTH + bmm_pkg::ACC_GUARD;

    // One extra bit so the rounding offset cannot wrap
    localparam logic signed [ACC_W:0] HALF  = 1 << (FRAC_WIDTH - 1);
    localparam logic signed [ACC_W:0] Q_MAX =
        {{(ACC_W - WIDTH + 2){1'b0}}, {(WIDTH - 1){1'b1}}};
    localparam logic signed [ACC_W:0] Q_MIN =
        {{(ACC_W - WIDTH + 2){1'b1}}, {(WIDTH - 1){1'b0}}};

    logic [WIDTH*LANES-1:0] q_next;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W:0]   rounded;
        logic signed [ACC_W:0]   shifted;
        logic signed [ACC_W:0]   clamped;

        assign acc     = acc_data[l*ACC_W +: ACC_W];
        assign rounded = {acc[ACC_W-1], acc} +
                         ((mode == bmm_pkg::RND_NEAREST) ? HALF : '0);
        assign shifted = rounded >>> FRAC_WIDTH;

        always_comb begin
            if (shifted > Q_MAX) begin
                clamped = Q_MAX;
            end else if (shifted < Q_MIN) begin
                clamped = Q_MIN;
            end else begin
                clamped = shifted;
            end
        end

        assign q_next[l*WIDTH +: WIDTH] = clamped[WIDTH-1:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            q_data <= q_next;
        end
    end

    // Dot products span several beats, so results never come back to back
    a_q_valid_pulse: assert property (
        @(posedge clk) disable iff (rst) q_valid |=> !q_valid
    ) else $error("q_valid held high for two cycles");

endmodule

/* hdl/dot_core.sv */
// ####################
// Dot product core
// ####################

`timescale 1ns/10ps

module dot_core #(
    parameter int WIDTH      = 16,
    parameter int BLOCK_SIZE = 2
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic                                                     in_valid,
    input  logic                                                     in_last,
    input  logic [WIDTH*BLOCK_SIZE-1:0]                              in_a,
    input  logic [WIDTH*BLOCK_SIZE-1:0]                              in_b,
    output logic                                                     acc_valid,
    output logic [(2*WIDTH+bmm_pkg::ACC_GUARD)*BLOCK_SIZE-1:0]       acc_data
);

    localparam int PROD_W = 2 * WIDTH;
    localparam int ACC_W  = PROD_W + bmm_pkg::ACC_GUARD;

    for (genvar l = 0; l < BLOCK_SIZE; l++) begin : g_lane
        logic signed [WIDTH-1:0]  lane_a;
        logic signed [WIDTH-1:0]  lane_b;
        logic signed [PROD_W-1:0] prod;
        logic signed [ACC_W-1:0]  sum;
        logic signed [ACC_W-1:0]  sum_next;

        assign lane_a = in_a[l*WIDTH +: WIDTH];
        assign lane_b = in_b[l*WIDTH +: WIDTH];
        assign prod   = lane_a * lane_b;

        // Sign-extend the product into the guard bits
        assign sum_next = sum + {{bmm_pkg::ACC_GUARD{prod[PROD_W-1]}}, prod};

        // Running sum, cleared once the last beat is taken
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                sum <= '0;
            end else if (in_valid) begin
                if (in_last) begin
                    sum <= '0;
                end else begin
                    sum <= sum_next;
                end
            end
        end

        // Final sum includes the product of the last beat
        always_ff @(posedge clk) begin
            if (in_valid && in_last) begin
                acc_data[l*ACC_W +: ACC_W] <= sum_next;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= in_valid && in_last;
        end
    end

endmodule

/* hdl/bmm_pkg.sv */
// ####################
// Block matmul shared types
// ####################

package bmm_pkg;

    // Extra accumulator bits above the full product width
    localparam int ACC_GUARD = 8;

    // Requantization rounding
    typedef enum logic {
        RND_TRUNC   = 1'b0,
        RND_NEAREST = 1'b1
    } round_mode_t;

    // Block-to-row converter states
    typedef enum logic [1:0] {
        CONV_IDLE  = 2'd0,
        CONV_WRITE = 2'd1,
        CONV_READ  = 2'd2,
        CONV_DONE  = 2'd3
    } conv_state_t;

endpackage
